/* src/pad_pkg.sv */
package pad_pkg;

  // Lanes per peripheral function with pads mapped onto them round robin
  localparam int LANES = 4;

  // Drive strength and pull bits that pass to the pad cell untouched
  localparam int PAD_CFG_W = 6;

  // Function driving a pad
  typedef enum logic [1:0] {
    FUNC_GPIO  = 2'd0,  // Reset value
    FUNC_UART  = 2'd1,
    FUNC_SPI   = 2'd2,
    FUNC_TIMER = 2'd3
  } pad_func_e;

  typedef logic [PAD_CFG_W-1:0] pad_cfg_t;

endpackage

/* src/cmd_pkg.sv */
package cmd_pkg;

  localparam int PAD_IDX_W = 6;
  localparam int PAYLOAD_W = 8;

  typedef enum logic [1:0] {
    CMD_NOP     = 2'd0,
    CMD_SET_MUX = 2'd1,
    CMD_SET_CFG = 2'd2,
    CMD_RSVD    = 2'd3   // Handled like a NOP
  } cmd_kind_e;

  // Payload seen as a function select
  typedef struct packed {
    logic [PAYLOAD_W-$bits(pad_pkg::pad_func_e)-1:0] unused;
    pad_pkg::pad_func_e                                func;
  } mux_view_t;

  // Payload seen as pad configuration
  typedef struct packed {
    logic [PAYLOAD_W-pad_pkg::PAD_CFG_W-1:0] unused;
    pad_pkg::pad_cfg_t                         cfg;
  } cfg_view_t;

  typedef union packed {
    mux_view_t mux;
    cfg_view_t cfg;
  } pad_payload_u;

  typedef struct packed {
    cmd_kind_e             kind;
    logic [PAD_IDX_W-1:0]  pad_idx;
    pad_payload_u          payload;
  } cmd_word_t;

endpackage

/* src/cmd_fifo.sv */
module cmd_fifo #(
  parameter int CMD_CREDITS = 4
) (
  input  logic               ref_clk_i,
  input  logic               reset_i,

  input  logic               cmd_valid_i,
  input  cmd_pkg::cmd_word_t cmd_word_i,
  input  logic               pop_i,

  output logic               head_valid_o,
  output cmd_pkg::cmd_word_t head_word_o,
  output logic               cmd_credit_o
);

  localparam int PTR_W = (CMD_CREDITS > 1) ? $clog2(CMD_CREDITS) : 1;
  localparam int CNT_W = $clog2(CMD_CREDITS + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(CMD_CREDITS - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CMD_CREDITS);

  cmd_pkg::cmd_word_t mem_q [CMD_CREDITS];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             credit_q;
  logic             full;
  logic             wr_en;

  // Depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (count_q == FULL_CNT);
  assign wr_en = cmd_valid_i && !full;  // Host out of credits, word is lost

  always_ff @(posedge ref_clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= cmd_word_i;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({wr_en, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // One credit back per consumed word
      credit_q <= pop_i;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_word_o  = mem_q[rd_ptr_q];
  assign cmd_credit_o = credit_q;

endmodule

/* src/pad_cfg_regs.sv */
module pad_cfg_regs #(
  parameter int N_PADS = 16
) (
  input  logic                                ref_clk_i,
  input  logic                                reset_i,

  input  logic                                head_valid_i,
  input  cmd_pkg::cmd_word_t                  head_word_i,
  input  logic                                cfg_hold_i,
  output logic                                pop_o,

  output pad_pkg::pad_func_e [N_PADS-1:0]     pad_sel_o,
  output pad_pkg::pad_cfg_t  [N_PADS-1:0]     pad_cfg_o
);

  localparam int SEL_W = $clog2(N_PADS);

  pad_pkg::pad_func_e [N_PADS-1:0] pad_sel_q;
  pad_pkg::pad_cfg_t  [N_PADS-1:0] pad_cfg_q;

  cmd_pkg::pad_payload_u payload;
  logic                  idx_ok;
  logic [SEL_W-1:0]      idx;

  // Head is consumed whenever present and the SoC side is not holding
  assign pop_o = head_valid_i && !cfg_hold_i;

  assign payload = head_word_i.payload;
  assign idx_ok  = (head_word_i.pad_idx < N_PADS);
  assign idx     = head_word_i.pad_idx[SEL_W-1:0];

  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      for (int p = 0; p < N_PADS; p++) begin
        pad_sel_q[p] <= pad_pkg::FUNC_GPIO;
      end
      pad_cfg_q <= '0;
    end else if (pop_o && idx_ok) begin
      case (head_word_i.kind)
        cmd_pkg::CMD_SET_MUX: pad_sel_q[idx] <= payload.mux.func;
        cmd_pkg::CMD_SET_CFG: pad_cfg_q[idx] <= payload.cfg.cfg;
        default: ;  // NOP and reserved only cost a credit
      endcase
    end
  end

  assign pad_sel_o = pad_sel_q;
  assign pad_cfg_o = pad_cfg_q;

endmodule

/* src/pad_mux.sv */
module pad_mux #(
  parameter int N_PADS = 16
) (
  input  pad_pkg::pad_func_e [N_PADS-1:0] pad_sel_i,

  input  logic [N_PADS-1:0]               gpio_out_i,
  input  logic [N_PADS-1:0]               gpio_dir_i,
  input  logic [pad_pkg::LANES-1:0]       uart_out_i,
  input  logic [pad_pkg::LANES-1:0]       uart_oe_i,
  input  logic [pad_pkg::LANES-1:0]       spi_out_i,
  input  logic [pad_pkg::LANES-1:0]       spi_oe_i,
  input  logic [pad_pkg::LANES-1:0]       timer_i,

  input  logic [N_PADS-1:0]               pad_in_sync_i,

  output logic [N_PADS-1:0]               pad_out_o,
  output logic [N_PADS-1:0]               pad_oe_o,
  output logic [pad_pkg::LANES-1:0]       uart_in_o,
  output logic [pad_pkg::LANES-1:0]       spi_in_o
);

  // One function drives each pad
  always_comb begin
    for (int p = 0; p < N_PADS; p++) begin
      case (pad_sel_i[p])
        pad_pkg::FUNC_UART: begin
          pad_out_o[p] = uart_out_i[p % pad_pkg::LANES];
          pad_oe_o[p]  = uart_oe_i[p % pad_pkg::LANES];
        end
        pad_pkg::FUNC_SPI: begin
          pad_out_o[p] = spi_out_i[p % pad_pkg::LANES];
          pad_oe_o[p]  = spi_oe_i[p % pad_pkg::LANES];
        end
        pad_pkg::FUNC_TIMER: begin
          pad_out_o[p] = timer_i[p % pad_pkg::LANES];
          pad_oe_o[p]  = 1'b1;  // Timers only drive
        end
        default: begin
          pad_out_o[p] = gpio_out_i[p];
          pad_oe_o[p]  = gpio_dir_i[p];
        end
      endcase
    end
  end

  // Input side
  // Ascending scan so the highest pad on a lane wins
  always_comb begin
    uart_in_o = '0;
    spi_in_o  = '0;
    for (int p = 0; p < N_PADS; p++) begin
      if (pad_sel_i[p] == pad_pkg::FUNC_UART) begin
        uart_in_o[p % pad_pkg::LANES] = pad_in_sync_i[p];
      end
      if (pad_sel_i[p] == pad_pkg::FUNC_SPI) begin
        spi_in_o[p % pad_pkg::LANES] = pad_in_sync_i[p];
      end
    end
  end

endmodule

/* src/pad_sampler.sv */
module pad_sampler #(
  parameter int N_PADS = 16
) (
  input  logic              ref_clk_i,
  input  logic              reset_i,

  input  logic [N_PADS-1:0] pad_in_i,

  output logic [N_PADS-1:0] pad_in_sync_o,
  output logic [N_PADS-1:0] gpio_in_o,
  output logic [1:0]        bootsel_o
);

  logic [N_PADS-1:0] meta_q;
  logic [N_PADS-1:0] sync_q;
  logic              armed_q;
  logic              captured_q;
  logic [1:0]        bootsel_q;

  // Pads are asynchronous to ref_clk
  always_ff @(posedge ref_clk_i) begin
    meta_q <= pad_in_i;
    sync_q <= meta_q;
  end

  // Armed on the first edge out of reset, capture on the second
  always_ff @(posedge ref_clk_i) begin
    if (reset_i) begin
      armed_q    <= 1'b0;
      captured_q <= 1'b0;
      bootsel_q  <= '0;
    end else begin
      armed_q <= 1'b1;
      if (armed_q && !captured_q) begin
        bootsel_q  <= sync_q[N_PADS-1 -: 2];  // Top two pads
        captured_q <= 1'b1;
      end
    end
  end

  assign pad_in_sync_o = sync_q;
  assign gpio_in_o     = sync_q;
  assign bootsel_o     = bootsel_q;

endmodule

/* src/pad_subsys_top.sv */
module pad_subsys_top #(
  parameter int N_PADS      = 16,
  parameter int CMD_CREDITS = 4
) (
  input  logic                            ref_clk_i,
  input  logic                            reset_i,

  // Configuration commands from the SoC side
  input  logic                            cmd_valid_i,
  input  cmd_pkg::cmd_word_t              cmd_word_i,
  input  logic                            cfg_hold_i,
  output logic                            cmd_credit_o,

  // Peripheral side
  input  logic [N_PADS-1:0]               gpio_out_i,
  input  logic [N_PADS-1:0]               gpio_dir_i,
  input  logic [pad_pkg::LANES-1:0]       uart_out_i,
  input  logic [pad_pkg::LANES-1:0]       uart_oe_i,
  input  logic [pad_pkg::LANES-1:0]       spi_out_i,
  input  logic [pad_pkg::LANES-1:0]       spi_oe_i,
  input  logic [pad_pkg::LANES-1:0]       timer_i,

  // Pad side
  input  logic [N_PADS-1:0]               pad_in_i,
  output logic [N_PADS-1:0]               pad_out_o,
  output logic [N_PADS-1:0]               pad_oe_o,
  output pad_pkg::pad_cfg_t [N_PADS-1:0]  pad_cfg_o,

  output logic [N_PADS-1:0]               gpio_in_o,
  output logic [pad_pkg::LANES-1:0]       uart_in_o,
  output logic [pad_pkg::LANES-1:0]       spi_in_o,
  output logic [1:0]                      bootsel_o
);

  logic                            s_head_valid;
  cmd_pkg::cmd_word_t              s_head_word;
  logic                            s_pop;
  pad_pkg::pad_func_e [N_PADS-1:0] s_pad_sel;
  logic [N_PADS-1:0]               s_pad_in_sync;

  cmd_fifo #(
    .CMD_CREDITS   ( CMD_CREDITS   )
  ) u_cmd_fifo (
    .ref_clk_i     ( ref_clk_i     ),
    .reset_i       ( reset_i       ),
    .cmd_valid_i   ( cmd_valid_i   ),
    .cmd_word_i    ( cmd_word_i    ),
    .pop_i         ( s_pop         ),
    .head_valid_o  ( s_head_valid  ),
    .head_word_o   ( s_head_word   ),
    .cmd_credit_o  ( cmd_credit_o  )
  );

  pad_cfg_regs #(
    .N_PADS        ( N_PADS        )
  ) u_pad_cfg_regs (
    .ref_clk_i     ( ref_clk_i     ),
    .reset_i       ( reset_i       ),
    .head_valid_i  ( s_head_valid  ),
    .head_word_i   ( s_head_word   ),
    .cfg_hold_i    ( cfg_hold_i    ),
    .pop_o         ( s_pop         ),
    .pad_sel_o     ( s_pad_sel     ),
    .pad_cfg_o     ( pad_cfg_o     )
  );

  pad_mux #(
    .N_PADS        ( N_PADS        )
  ) u_pad_mux (
    .pad_sel_i     ( s_pad_sel     ),
    .gpio_out_i    ( gpio_out_i    ),
    .gpio_dir_i    ( gpio_dir_i    ),
    .uart_out_i    ( uart_out_i    ),
    .uart_oe_i     ( uart_oe_i     ),
    .spi_out_i     ( spi_out_i     ),
    .spi_oe_i      ( spi_oe_i      ),
    .timer_i       ( timer_i       ),
    .pad_in_sync_i ( s_pad_in_sync ),
    .pad_out_o     ( pad_out_o     ),
    .pad_oe_o      ( pad_oe_o      ),
    .uart_in_o     ( uart_in_o     ),
    .spi_in_o      ( spi_in_o      )
  );

  pad_sampler #(
    .N_PADS        ( N_PADS        )
  ) u_pad_sampler (
    .ref_clk_i     ( ref_clk_i     ),
    .reset_i       ( reset_i       ),
    .pad_in_i      ( pad_in_i      ),
    .pad_in_sync_o ( s_pad_in_sync ),
    .gpio_in_o     ( gpio_in_o     ),
    .bootsel_o     ( bootsel_o     )
  );

endmodule

/* bench/pad_ref_model.svh */
`ifndef PAD_REF_MODEL_SVH
`define PAD_REF_MODEL_SVH

// Shadow copy of the pad select and config registers
logic [1:0]                    model_sel [N_PADS];
logic [pad_pkg::PAD_CFG_W-1:0] model_cfg [N_PADS];

function automatic void clear_model();
  for (int p = 0; p < N_PADS; p++) begin
    model_sel[p] = 2'd0;  // GPIO
    model_cfg[p] = '0;
  end
endfunction

// Word layout is kind[15:14], pad index[13:8], payload[7:0]
function automatic void apply_cmd(input logic [15:0] word);
  int idx;
  idx = int'(word[13:8]);
  if (idx < N_PADS && word[15:14] == 2'd1) begin
    model_sel[idx] = word[1:0];
  end
  if (idx < N_PADS && word[15:14] == 2'd2) begin
    model_cfg[idx] = word[pad_pkg::PAD_CFG_W-1:0];
  end
endfunction

function automatic logic [N_PADS-1:0] predict_out(input logic [N_PADS-1:0] gpio,
    input logic [LANES-1:0] uart, input logic [LANES-1:0] spi, input logic [LANES-1:0] tmr);
  logic [N_PADS-1:0] v;
  for (int p = 0; p < N_PADS; p++) begin
    case (model_sel[p])
      2'd1:    v[p] = uart[p % LANES];
      2'd2:    v[p] = spi[p % LANES];
      2'd3:    v[p] = tmr[p % LANES];
      default: v[p] = gpio[p];
    endcase
  end
  return v;
endfunction

function automatic logic [N_PADS-1:0] predict_oe(input logic [N_PADS-1:0] dir,
    input logic [LANES-1:0] uart, input logic [LANES-1:0] spi);
  logic [N_PADS-1:0] v;
  for (int p = 0; p < N_PADS; p++) begin
    case (model_sel[p])
      2'd1:    v[p] = uart[p % LANES];
      2'd2:    v[p] = spi[p % LANES];
      2'd3:    v[p] = 1'b1;
      default: v[p] = dir[p];
    endcase
  end
  return v;
endfunction

// Highest pad on a lane wins, so scan downward and keep the first hit
function automatic logic [LANES-1:0] lane_input(input logic [1:0] func,
    input logic [N_PADS-1:0] pins);
  logic [LANES-1:0] v;
  logic [LANES-1:0] taken;
  v     = '0;
  taken = '0;
  for (int p = N_PADS - 1; p >= 0; p--) begin
    if (model_sel[p] == func && !taken[p % LANES]) begin
      v[p % LANES]     = pins[p];
      taken[p % LANES] = 1'b1;
    end
  end
  return v;
endfunction

function automatic logic [N_PADS*pad_pkg::PAD_CFG_W-1:0] flat_cfg();
  logic [N_PADS*pad_pkg::PAD_CFG_W-1:0] v;
  for (int p = 0; p < N_PADS; p++) begin
    v[p*pad_pkg::PAD_CFG_W +: pad_pkg::PAD_CFG_W] = model_cfg[p];
  end
  return v;
endfunction

`endif

/* bench/tb_pad_subsys.sv */
module tb_pad_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_PADS      = 16;
  localparam int CMD_CREDITS = 4;
  localparam int LANES       = pad_pkg::LANES;
  localparam int CFG_W       = N_PADS * pad_pkg::PAD_CFG_W;
  localparam int WAIT_LIMIT  = 50;

  logic              ref_clk;
  logic              reset;
  logic              cmd_valid;
  logic [15:0]       cmd_word;
  logic              cfg_hold;
  logic              cmd_credit;
  logic [N_PADS-1:0] gpio_out;
  logic [N_PADS-1:0] gpio_dir;
  logic [N_PADS-1:0] pad_in;
  logic [N_PADS-1:0] pad_out;
  logic [N_PADS-1:0] pad_oe;
  logic [N_PADS-1:0] gpio_in;
  logic [LANES-1:0]  uart_out;
  logic [LANES-1:0]  uart_oe;
  logic [LANES-1:0]  spi_out;
  logic [LANES-1:0]  spi_oe;
  logic [LANES-1:0]  timer;
  logic [LANES-1:0]  uart_in;
  logic [LANES-1:0]  spi_in;
  logic [CFG_W-1:0]  pad_cfg;
  logic [1:0]        bootsel;
  logic [1:0]        boot_pins;

  integer seed;
  int     credits;       // Host side credit counter
  int     pulses;        // Credit pulses seen so far
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  bit     timed_out;

  `include "pad_ref_model.svh"

  pad_subsys_top #(
    .N_PADS       ( N_PADS      ),
    .CMD_CREDITS  ( CMD_CREDITS )
  ) u_dut (
    .ref_clk_i    ( ref_clk     ),
    .reset_i      ( reset       ),
    .cmd_valid_i  ( cmd_valid   ),
    .cmd_word_i   ( cmd_word    ),
    .cfg_hold_i   ( cfg_hold    ),
    .cmd_credit_o ( cmd_credit  ),
    .gpio_out_i   ( gpio_out    ),
    .gpio_dir_i   ( gpio_dir    ),
    .uart_out_i   ( uart_out    ),
    .uart_oe_i    ( uart_oe     ),
    .spi_out_i    ( spi_out     ),
    .spi_oe_i     ( spi_oe      ),
    .timer_i      ( timer       ),
    .pad_in_i     ( pad_in      ),
    .pad_out_o    ( pad_out     ),
    .pad_oe_o     ( pad_oe      ),
    .pad_cfg_o    ( pad_cfg     ),
    .gpio_in_o    ( gpio_in     ),
    .uart_in_o    ( uart_in     ),
    .spi_in_o     ( spi_in      ),
    .bootsel_o    ( bootsel     )
  );

  initial begin
    ref_clk = 1'b0;
    forever #10 ref_clk = ~ref_clk;
  end

  // Advance one cycle and count a credit pulse at the falling edge
  task automatic tick();
    @(negedge ref_clk);
    if (cmd_credit) begin
      credits++;
      pulses++;
    end
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test();
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_errors || timed_out) begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - test_errors);
    end else begin
      $display("test %s passed", name);
    end
  endtask

  task automatic wait_credits(input int want);
    int n;
    n = 0;
    while (credits < want && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (credits < want) begin
      $display("Timeout: only %0d of %0d credits came back within %0d cycles",
               credits, want, WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic send_cmd(input logic [15:0] word);
    wait_credits(1);
    if (!timed_out) begin
      cmd_valid = 1'b1;
      cmd_word  = word;
      credits--;
      tick();
      cmd_valid = 1'b0;
    end
  endtask

  function automatic logic [15:0] make_word(input logic [1:0] kind, input int idx,
                                            input logic [7:0] payload);
    logic [5:0] idx6;
    idx6 = idx[5:0];
    return {kind, idx6, payload};
  endfunction

  task automatic shuffle_periph();
    logic [31:0] r;
    logic [31:0] s;
    r = $random(seed);
    s = $random(seed);
    gpio_out = r[N_PADS-1:0];
    gpio_dir = r[31 -: N_PADS];
    {uart_out, uart_oe, spi_out, spi_oe, timer} = s[5*LANES-1:0];
  endtask

  task automatic check_outputs(input string name);
    check_value({name, " pad_out"}, predict_out(gpio_out, uart_out, spi_out, timer), pad_out);
    check_value({name, " pad_oe"}, predict_oe(gpio_dir, uart_oe, spi_oe), pad_oe);
    check_value({name, " pad_cfg"}, flat_cfg(), pad_cfg);
  endtask

  task automatic test_reset();
    start_test();
    shuffle_periph();
    tick();
    check_outputs("reset");
    repeat (8) tick();  // Idle bus returns no credits
    check_value("reset credit pulses", 0, pulses);
    check_value("reset bootsel", boot_pins, bootsel);
    finish_test("reset");
  endtask

  task automatic test_random_cmds();
    logic [31:0] r;
    logic [15:0] word;
    start_test();
    for (int i = 0; i < 40 && !timed_out; i++) begin
      r    = $random(seed);
      word = make_word(r[0] ? 2'd1 : 2'd2, int'(r[15:8]) % N_PADS, r[23:16]);
      send_cmd(word);
      apply_cmd(word);
      wait_credits(CMD_CREDITS);
      shuffle_periph();
      tick();
      check_outputs("random_cmds");
    end
    finish_test("random_cmds");
  endtask

  task automatic test_inputs();
    logic [31:0] r;
    start_test();
    for (int i = 0; i < 20; i++) begin
      r      = $random(seed);
      pad_in = r[N_PADS-1:0];
      repeat (3) tick();  // Two flop sync plus margin
      check_value("inputs gpio_in", pad_in, gpio_in);
      check_value("inputs uart_in", lane_input(2'd1, pad_in), uart_in);
      check_value("inputs spi_in", lane_input(2'd2, pad_in), spi_in);
    end
    check_value("inputs bootsel held", boot_pins, bootsel);
    finish_test("inputs");
  endtask

  task automatic test_hold();
    logic [15:0] burst [CMD_CREDITS];
    logic [31:0] r;
    int          start_pulses;
    int          target;
    start_test();
    r      = $random(seed);
    target = int'(r[7:0]) % N_PADS;
    // Mux and cfg writes alternate on one pad so later writes must win
    for (int i = 0; i < CMD_CREDITS; i++) begin
      r        = $random(seed);
      burst[i] = make_word((i % 2 == 0) ? 2'd1 : 2'd2, target, {r[7:2], i[1:0]});
    end
    cfg_hold     = 1'b1;
    start_pulses = pulses;
    for (int i = 0; i < CMD_CREDITS; i++) begin
      send_cmd(burst[i]);
    end
    repeat (6) tick();
    check_outputs("hold frozen");
    check_value("hold credits", 0, credits);
    check_value("hold credit pulses", start_pulses, pulses);
    cfg_hold = 1'b0;
    wait_credits(CMD_CREDITS);
    repeat (4) tick();
    check_value("hold released pulses", CMD_CREDITS, pulses - start_pulses);
    for (int i = 0; i < CMD_CREDITS; i++) begin
      apply_cmd(burst[i]);
    end
    check_outputs("hold released");
    finish_test("hold");
  endtask

  task automatic test_ignored();
    logic [31:0] r;
    logic [15:0] word;
    int          start_pulses;
    start_test();
    for (int i = 0; i < 4 && !timed_out; i++) begin
      r = $random(seed);
      case (i)
        0:       word = make_word(2'd0, int'(r[3:0]), r[15:8]);  // NOP
        1:       word = make_word(2'd3, int'(r[3:0]), r[15:8]);  // Reserved kind
        default: word = make_word((i == 2) ? 2'd1 : 2'd2,
                                  N_PADS + int'(r[21:16]) % (64 - N_PADS), r[15:8]);
      endcase
      start_pulses = pulses;
      send_cmd(word);
      apply_cmd(word);
      wait_credits(CMD_CREDITS);
      repeat (2) tick();
      check_value("ignored credit pulses", 1, pulses - start_pulses);
      check_outputs("ignored");
    end
    finish_test("ignored");
  endtask

  initial begin
    logic [31:0] r;
    seed         = 32'h06a8d6f4;
    credits      = CMD_CREDITS;
    pulses       = 0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    reset        = 1'b1;
    cmd_valid    = 1'b0;
    cmd_word     = '0;
    cfg_hold     = 1'b0;
    shuffle_periph();
    r         = $random(seed);
    pad_in    = r[N_PADS-1:0];
    boot_pins = pad_in[N_PADS-1 -: 2];  // Held stable until the input test
    clear_model();

    repeat (16) tick();
    reset = 1'b0;

    test_reset();
    if (!timed_out) test_random_cmds();
    if (!timed_out) test_inputs();
    if (!timed_out) test_hold();
    if (!timed_out) test_ignored();

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+bench
src/pad_pkg.sv
src/cmd_pkg.sv
src/cmd_fifo.sv
src/pad_cfg_regs.sv
src/pad_mux.sv
src/pad_sampler.sv
src/pad_subsys_top.sv
bench/tb_pad_subsys.sv

/* run.sh */
#!/bin/sh
# Build and run the pad subsystem testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_pad_subsys \
  -o tb_pad_subsys || { echo "build failed"; exit 1; }

./obj_dir/tb_pad_subsys > sim.log 2>&1

grep -q "Simulation finished: PASS" sim.log && echo "run passed, see sim.log" \
  || { echo "run failed, see sim.log"; exit 1; }
